// ==== common/mem_ctrl_params.svh ====
// widths and table depth of the request sequencer, included wherever the sizes are needed
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// byte address and transfer size
`define ADDR_W 32
`define SIZE_W 10

// loop counts
`define LOOP_W 8

// descriptor tables
`define DESC_IDX_W 3
`define DESC_DEPTH 8

`endif

// ==== common/mem_ctrl_pkg.sv ====
// state, select and descriptor types of the request sequencer, imported by RTL and testbench
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

  typedef enum logic [1:0] {
    RD_IDLE,  // waiting for start
    RD_LOAD,  // table word being fetched
    RD_BUSY   // issuing read requests
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_LOAD,
    WR_BUSY,
    WR_WAIT_DONE  // all beats out, waiting on memory
  } wr_state_e;

  typedef enum logic {
    CFG_RD,
    CFG_WR
  } cfg_sel_e;

  // two nested loops, inner runs fastest
  typedef struct packed {
    logic [`ADDR_W-1:0] base;
    logic [`SIZE_W-1:0] size;
    logic [`ADDR_W-1:0] inner_offset;
    logic [`LOOP_W-1:0] inner_max;
    logic [`ADDR_W-1:0] outer_offset;
    logic [`LOOP_W-1:0] outer_max;
  } rd_desc_t;

  typedef struct packed {
    logic [`ADDR_W-1:0] base;
    logic [`SIZE_W-1:0] size;
    logic [`ADDR_W-1:0] offset;
    logic [`LOOP_W-1:0] loop_max;
  } wr_desc_t;

endpackage

// ==== rtl/loop_counter.sv ====
// wrapping up-counter with a programmable maximum, used for every loop and index counter
module loop_counter #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,  // back to zero, wins over inc
  input  logic             inc,
  input  logic [width-1:0] max,
  output logic [width-1:0] count,
  output logic             wrap
);

  // last step of a pass
  assign wrap = inc && (count == max);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (wrap) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== rtl/desc_table.sv ====
// read and write descriptor tables, filled from the config port and read out by index
`include "mem_ctrl_params.svh"

module desc_table
  import mem_ctrl_pkg::*;
(
  input  logic                         clk,
  input  logic                         cfg_valid,
  input  cfg_sel_e                     cfg_sel,
  input  logic [`DESC_IDX_W-1:0]       cfg_idx,
  input  logic [$bits(rd_desc_t)-1:0]  cfg_data,
  input  logic [`DESC_IDX_W-1:0]       rd_idx,
  input  logic [`DESC_IDX_W-1:0]       wr_idx,
  output rd_desc_t                     rd_desc,
  output wr_desc_t                     wr_desc
);

  rd_desc_t rd_tbl [`DESC_DEPTH];
  wr_desc_t wr_tbl [`DESC_DEPTH];

  // ********************
  // config writes
  // ********************

  always_ff @(posedge clk) begin
    if (cfg_valid && (cfg_sel == CFG_RD)) begin
      rd_tbl[cfg_idx] <= rd_desc_t'(cfg_data);
    end
    if (cfg_valid && (cfg_sel == CFG_WR)) begin
      // write word sits in the low bits
      wr_tbl[cfg_idx] <= wr_desc_t'(cfg_data[$bits(wr_desc_t)-1:0]);
    end
  end

  // ********************
  // registered reads
  // ********************

  always_ff @(posedge clk) begin
    rd_desc <= rd_tbl[rd_idx];  // one cycle after the index
    wr_desc <= wr_tbl[wr_idx];
  end

endmodule

// ==== rd_path/rd_fsm.sv ====
// read sequencer FSM, walks the read descriptors and their two loops under the write throttle
`include "mem_ctrl_params.svh"

module rd_fsm
  import mem_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [`DESC_IDX_W-1:0] rd_desc_count,
  input  rd_desc_t               rd_desc,
  input  logic [`DESC_IDX_W-1:0] wr_idx,
  input  logic                   rd_ready,
  output logic                   rd_valid,
  output logic [`SIZE_W-1:0]     rd_size,
  output logic [`DESC_IDX_W-1:0] rd_idx,
  output logic                   addr_load,
  output logic                   addr_step,
  output logic                   inner_wrap
);

  rd_state_e              state;
  rd_state_e              state_next;
  logic [`DESC_IDX_W-1:0] last_idx;   // count minus one, held for the run
  logic [`DESC_IDX_W-1:0] idx_count;  // descriptor being issued
  logic                   idx_clear;
  logic                   idx_wrap;
  logic                   outer_wrap;
  logic                   rd_hs;

  assign idx_clear = (state == RD_IDLE) && start;
  assign rd_valid  = (state == RD_BUSY) && (idx_count <= wr_idx);  // throttle
  assign rd_hs     = rd_valid && rd_ready;
  assign addr_load = (state == RD_LOAD);
  assign addr_step = rd_hs;

  // table index runs one step ahead so the new word is there in RD_LOAD
  always_comb begin
    if (idx_clear || idx_wrap) begin
      rd_idx = '0;
    end else if (outer_wrap) begin
      rd_idx = idx_count + 1'b1;
    end else begin
      rd_idx = idx_count;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_idx <= '0;
    end else if (idx_clear) begin
      last_idx <= rd_desc_count;
    end
  end

  always_ff @(posedge clk) begin
    if (addr_load) rd_size <= rd_desc.size;
  end

  // ********************
  // loop counters
  // ********************

  loop_counter #(.width(`LOOP_W)) u_inner (
    .clk(clk), .reset(reset), .clear(addr_load), .inc(rd_hs),
    .max(rd_desc.inner_max), .count(), .wrap(inner_wrap)
  );

  loop_counter #(.width(`LOOP_W)) u_outer (
    .clk(clk), .reset(reset), .clear(addr_load), .inc(inner_wrap),
    .max(rd_desc.outer_max), .count(), .wrap(outer_wrap)
  );

  loop_counter #(.width(`DESC_IDX_W)) u_index (
    .clk(clk), .reset(reset), .clear(idx_clear), .inc(outer_wrap),
    .max(last_idx), .count(idx_count), .wrap(idx_wrap)
  );

  // ********************
  // state machine
  // ********************

  always_ff @(posedge clk) begin
    if (reset) state <= RD_IDLE;
    else       state <= state_next;
  end

  always_comb begin
    state_next = state;
    case (state)
      RD_IDLE: if (start) state_next = RD_LOAD;
      RD_LOAD: state_next = RD_BUSY;  // single fetch cycle
      RD_BUSY: if (outer_wrap) state_next = idx_wrap ? RD_IDLE : RD_LOAD;
      default: state_next = RD_IDLE;
    endcase
  end

  // a stalled request stays up with the same size
  assert property (@(posedge clk) disable iff (reset)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_size));

  // once the write side lets a descriptor through it never closes on it again
  assert property (@(posedge clk) disable iff (reset)
    (state == RD_BUSY) && (idx_count <= wr_idx) |=>
      (state != RD_BUSY) || (idx_count <= wr_idx));

endmodule

// ==== rd_path/rd_addr_gen.sv ====
// nested-loop read address registers, loaded and stepped by the read FSM
`include "mem_ctrl_params.svh"

module rd_addr_gen
  import mem_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               addr_load,
  input  logic               addr_step,
  input  logic               inner_wrap,
  input  rd_desc_t           rd_desc,
  output logic [`ADDR_W-1:0] rd_addr
);

  logic [`ADDR_W-1:0] row_addr;  // start of the current outer pass
  logic [`ADDR_W-1:0] row_next;

  assign row_next = row_addr + rd_desc.outer_offset;

  always_ff @(posedge clk) begin
    if (reset) begin
      row_addr <= '0;
      rd_addr  <= '0;
    end else if (addr_load) begin
      row_addr <= rd_desc.base;
      rd_addr  <= rd_desc.base;
    end else if (addr_step && inner_wrap) begin
      // new row, inner offset starts over
      row_addr <= row_next;
      rd_addr  <= row_next;
    end else if (addr_step) begin
      rd_addr <= rd_addr + rd_desc.inner_offset;
    end
  end

endmodule

// ==== wr_path/wr_fsm.sv ====
// write sequencer FSM, issues the beats of each write descriptor and waits for completion
`include "mem_ctrl_params.svh"

module wr_fsm
  import mem_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [`DESC_IDX_W-1:0] wr_desc_count,
  input  wr_desc_t               wr_desc,
  input  logic                   wr_ready,
  input  logic                   wr_done,
  output logic                   wr_valid,
  output logic [`ADDR_W-1:0]     wr_addr,
  output logic [`SIZE_W-1:0]     wr_size,
  output logic [`DESC_IDX_W-1:0] wr_idx,
  output logic                   done
);

  wr_state_e              state;
  wr_state_e              state_next;
  logic [`DESC_IDX_W-1:0] last_idx;
  logic [`DESC_IDX_W-1:0] idx_count;  // descriptors finished so far
  logic                   idx_clear;
  logic                   idx_inc;
  logic                   last_desc;
  logic                   beat_wrap;
  logic                   wr_hs;

  assign idx_clear = (state == WR_IDLE) && start;
  assign last_desc = (idx_count == last_idx);
  // index parks on the last entry so reads stay unthrottled after the run
  assign idx_inc   = (state == WR_WAIT_DONE) && wr_done && !last_desc;
  assign done      = (state == WR_WAIT_DONE) && wr_done && last_desc;
  assign wr_valid  = (state == WR_BUSY);
  assign wr_hs     = wr_valid && wr_ready;

  always_comb begin
    if (idx_clear) wr_idx = '0;
    else if (idx_inc) wr_idx = idx_count + 1'b1;  // next word lands in WR_LOAD
    else wr_idx = idx_count;
  end

  always_ff @(posedge clk) begin
    if (reset) last_idx <= '0;
    else if (idx_clear) last_idx <= wr_desc_count;
  end

  // ********************
  // address and size
  // ********************

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
    end else if (state == WR_LOAD) begin
      wr_addr <= wr_desc.base;
    end else if (wr_hs) begin
      wr_addr <= wr_addr + wr_desc.offset;
    end
  end

  always_ff @(posedge clk) begin
    if (state == WR_LOAD) wr_size <= wr_desc.size;
  end

  loop_counter #(.width(`LOOP_W)) u_beat (
    .clk(clk), .reset(reset), .clear(state == WR_LOAD), .inc(wr_hs),
    .max(wr_desc.loop_max), .count(), .wrap(beat_wrap)
  );

  loop_counter #(.width(`DESC_IDX_W)) u_index (
    .clk(clk), .reset(reset), .clear(idx_clear), .inc(idx_inc),
    .max(last_idx), .count(idx_count), .wrap()
  );

  // ********************
  // state machine
  // ********************

  always_ff @(posedge clk) begin
    if (reset) state <= WR_IDLE;
    else       state <= state_next;
  end

  always_comb begin
    state_next = state;
    case (state)
      WR_IDLE:      if (start) state_next = WR_LOAD;
      WR_LOAD:      state_next = WR_BUSY;
      WR_BUSY:      if (beat_wrap) state_next = WR_WAIT_DONE;
      WR_WAIT_DONE: if (wr_done) state_next = last_desc ? WR_IDLE : WR_LOAD;
      default:      state_next = WR_IDLE;
    endcase
  end

  // a stalled beat stays up with the same address and size
  assert property (@(posedge clk) disable iff (reset)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_size));

endmodule

// ==== rtl/mem_ctrl_top.sv ====
// top of the request sequencer, joins the descriptor table with the read and write paths
`include "mem_ctrl_params.svh"

module mem_ctrl_top
  import mem_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  // descriptor config
  input  logic                        cfg_valid,
  input  cfg_sel_e                    cfg_sel,
  input  logic [`DESC_IDX_W-1:0]      cfg_idx,
  input  logic [$bits(rd_desc_t)-1:0] cfg_data,
  // run control
  input  logic                        start,
  input  logic [`DESC_IDX_W-1:0]      rd_desc_count,
  input  logic [`DESC_IDX_W-1:0]      wr_desc_count,
  // read requests
  output logic                        rd_valid,
  input  logic                        rd_ready,
  output logic [`ADDR_W-1:0]          rd_addr,
  output logic [`SIZE_W-1:0]          rd_size,
  // write requests
  output logic                        wr_valid,
  input  logic                        wr_ready,
  output logic [`ADDR_W-1:0]          wr_addr,
  output logic [`SIZE_W-1:0]          wr_size,
  input  logic                        wr_done,
  output logic                        done
);

  logic [`DESC_IDX_W-1:0] rd_idx;
  logic [`DESC_IDX_W-1:0] wr_idx;  // also the read throttle
  rd_desc_t               rd_desc;
  wr_desc_t               wr_desc;
  logic                   addr_load;
  logic                   addr_step;
  logic                   inner_wrap;

  desc_table u_desc_table (
    .clk(clk), .cfg_valid(cfg_valid), .cfg_sel(cfg_sel), .cfg_idx(cfg_idx),
    .cfg_data(cfg_data), .rd_idx(rd_idx), .wr_idx(wr_idx),
    .rd_desc(rd_desc), .wr_desc(wr_desc)
  );

  rd_fsm u_rd_fsm (
    .clk(clk), .reset(reset), .start(start), .rd_desc_count(rd_desc_count),
    .rd_desc(rd_desc), .wr_idx(wr_idx), .rd_ready(rd_ready),
    .rd_valid(rd_valid), .rd_size(rd_size), .rd_idx(rd_idx),
    .addr_load(addr_load), .addr_step(addr_step), .inner_wrap(inner_wrap)
  );

  rd_addr_gen u_rd_addr_gen (
    .clk(clk), .reset(reset), .addr_load(addr_load), .addr_step(addr_step),
    .inner_wrap(inner_wrap), .rd_desc(rd_desc), .rd_addr(rd_addr)
  );

  wr_fsm u_wr_fsm (
    .clk(clk), .reset(reset), .start(start), .wr_desc_count(wr_desc_count),
    .wr_desc(wr_desc), .wr_ready(wr_ready), .wr_done(wr_done),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_size(wr_size),
    .wr_idx(wr_idx), .done(done)
  );

endmodule

// ==== dv/mem_ctrl_tb.sv ====
// self-checking testbench of the request sequencer, run by the simulator as the top module
`include "mem_ctrl_params.svh"

module mem_ctrl_tb
  import mem_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        cfg_valid;
  cfg_sel_e                    cfg_sel;
  logic [`DESC_IDX_W-1:0]      cfg_idx;
  logic [$bits(rd_desc_t)-1:0] cfg_data;
  logic                        start;
  logic [`DESC_IDX_W-1:0]      rd_desc_count;
  logic [`DESC_IDX_W-1:0]      wr_desc_count;
  logic                        rd_valid;
  logic                        rd_ready;
  logic [`ADDR_W-1:0]          rd_addr;
  logic [`SIZE_W-1:0]          rd_size;
  logic                        wr_valid;
  logic                        wr_ready;
  logic [`ADDR_W-1:0]          wr_addr;
  logic [`SIZE_W-1:0]          wr_size;
  logic                        wr_done;
  logic                        done;

  int                 seed = 32'h6ec6;
  rd_desc_t           rd_tab [`DESC_DEPTH];
  wr_desc_t           wr_tab [`DESC_DEPTH];
  logic [`ADDR_W-1:0] exp_rd_addr [$];
  logic [`SIZE_W-1:0] exp_rd_size [$];
  int                 exp_rd_need [$];  // wr_done total a read must wait for
  logic [`ADDR_W-1:0] exp_wr_addr [$];
  logic [`SIZE_W-1:0] exp_wr_size [$];
  int                 exp_wr_need [$];
  bit                 exp_wr_last [$];

  // comparator state
  int                 wr_done_total = 0;
  int                 done_total = 0;
  int                 writes_finished = 0;  // write descriptors with all beats out
  int                 need = 0;
  bit                 prev_rd_stall = 1'b0;
  bit                 prev_wr_stall = 1'b0;
  logic [`ADDR_W-1:0] prev_rd_addr = '0;
  logic [`SIZE_W-1:0] prev_rd_size = '0;
  logic [`ADDR_W-1:0] prev_wr_addr = '0;
  logic [`SIZE_W-1:0] prev_wr_size = '0;

  // run control, owned by the stimulus process
  int                 runs_started = 0;
  int                 wr_goal = 0;
  int                 dones_given = 0;
  int                 delay_left = 0;
  int                 cycle_limit = 0;
  int                 run_start_cycle = 0;
  int                 cycle_count = 0;
  bit                 running = 1'b0;

  mem_ctrl_top uut (
    .clk(clk), .reset(reset), .cfg_valid(cfg_valid), .cfg_sel(cfg_sel),
    .cfg_idx(cfg_idx), .cfg_data(cfg_data), .start(start),
    .rd_desc_count(rd_desc_count), .wr_desc_count(wr_desc_count),
    .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_addr(rd_addr), .rd_size(rd_size),
    .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_size(wr_size),
    .wr_done(wr_done), .done(done)
  );

  always #5 clk = ~clk;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // address of one request, base + outer * outer_offset + inner * inner_offset
  function automatic logic [`ADDR_W-1:0] ref_addr(logic [`ADDR_W-1:0] base, int outer,
      logic [`ADDR_W-1:0] outer_off, int inner, logic [`ADDR_W-1:0] inner_off);
    return base + `ADDR_W'(outer) * outer_off + `ADDR_W'(inner) * inner_off;
  endfunction

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ********************
  // stimulus
  // ********************

  task automatic load_tables(int rd_n, int wr_n);
    rd_desc_t rd;
    wr_desc_t wr;
    for (int k = 0; k < rd_n; k++) begin
      rd.base         = `ADDR_W'($random(seed));
      rd.size         = `SIZE_W'(rand_below(1 << `SIZE_W));
      rd.inner_offset = `ADDR_W'($random(seed));
      rd.inner_max    = `LOOP_W'(rand_below(4));
      rd.outer_offset = `ADDR_W'($random(seed));
      rd.outer_max    = `LOOP_W'(rand_below(3));
      rd_tab[k] = rd;
      @(negedge clk);
      cfg_valid = 1'b1;
      cfg_sel   = CFG_RD;
      cfg_idx   = `DESC_IDX_W'(k);
      cfg_data  = rd;
    end
    for (int k = 0; k < wr_n; k++) begin
      wr.base     = `ADDR_W'($random(seed));
      wr.size     = `SIZE_W'(rand_below(1 << `SIZE_W));
      wr.offset   = `ADDR_W'($random(seed));
      wr.loop_max = `LOOP_W'(rand_below(6));
      wr_tab[k] = wr;
      @(negedge clk);
      cfg_valid = 1'b1;
      cfg_sel   = CFG_WR;
      cfg_idx   = `DESC_IDX_W'(k);
      cfg_data  = '0;
      cfg_data[$bits(wr_desc_t)-1:0] = wr;  // low bits carry the write word
    end
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic fill_expected(int rd_n, int wr_n, int base);
    for (int k = 0; k < rd_n; k++) begin
      for (int o = 0; o <= int'(rd_tab[k].outer_max); o++) begin
        for (int i = 0; i <= int'(rd_tab[k].inner_max); i++) begin
          exp_rd_addr.push_back(ref_addr(rd_tab[k].base, o, rd_tab[k].outer_offset,
                                         i, rd_tab[k].inner_offset));
          exp_rd_size.push_back(rd_tab[k].size);
          exp_rd_need.push_back(base + k);  // k completions before descriptor k
        end
      end
    end
    for (int k = 0; k < wr_n; k++) begin
      for (int b = 0; b <= int'(wr_tab[k].loop_max); b++) begin
        exp_wr_addr.push_back(ref_addr(wr_tab[k].base, 0, '0, b, wr_tab[k].offset));
        exp_wr_size.push_back(wr_tab[k].size);
        exp_wr_need.push_back(base + k);
        exp_wr_last.push_back(b == int'(wr_tab[k].loop_max));
      end
    end
  endtask

  task automatic run_once();
    int rd_n;
    int wr_n;
    wr_n = 1 + rand_below(`DESC_DEPTH);
    rd_n = 1 + rand_below(wr_n);  // reads never outnumber writes
    load_tables(rd_n, wr_n);
    fill_expected(rd_n, wr_n, wr_done_total);
    wr_goal = wr_done_total + wr_n;
    runs_started++;
    cycle_limit = 40 * (exp_rd_addr.size() + exp_wr_addr.size()) + 1000;
    run_start_cycle = cycle_count;
    running = 1'b1;
    @(negedge clk);
    start         = 1'b1;
    rd_desc_count = `DESC_IDX_W'(rd_n - 1);
    wr_desc_count = `DESC_IDX_W'(wr_n - 1);
    @(negedge clk);
    start = 1'b0;
    while (done_total < runs_started) @(negedge clk);
    repeat (10) @(negedge clk);  // room for a stray second done
    running = 1'b0;
  endtask

  task automatic drive_ready();
    forever begin
      @(negedge clk);
      rd_ready = (rand_below(4) != 0);
      wr_ready = (rand_below(3) != 0);
    end
  endtask

  // memory side completion of each write descriptor
  task automatic answer_wr_done();
    forever begin
      @(negedge clk);
      wr_done = 1'b0;
      // the last completion waits until every read is through
      if (writes_finished > dones_given &&
          !(writes_finished == wr_goal && exp_rd_addr.size() != 0)) begin
        if (delay_left == 0) begin
          wr_done = 1'b1;
          dones_given++;
          delay_left = rand_below(6);
        end else begin
          delay_left--;
        end
      end
    end
  endtask

  initial begin
    reset         = 1'b1;
    cfg_valid     = 1'b0;
    cfg_sel       = CFG_RD;
    cfg_idx       = '0;
    cfg_data      = '0;
    start         = 1'b0;
    rd_desc_count = '0;
    wr_desc_count = '0;
    rd_ready      = 1'b0;
    wr_ready      = 1'b0;
    wr_done       = 1'b0;
    fork
      drive_ready();
      answer_wr_done();
    join_none
    repeat (2) @(negedge clk);
    reset = 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_value("rd_valid", 32'(rd_valid), 32'd0);
      check_value("wr_valid", 32'(wr_valid), 32'd0);
      check_value("done", 32'(done), 32'd0);
    end
    run_once();
    run_once();  // back to back run from idle
    if (done_total == 2 && exp_rd_addr.size() == 0 && exp_wr_addr.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "runs ended without the expected completions");
    end
  end

  // ********************
  // comparator
  // ********************

  always @(posedge clk) begin
    if (!reset) begin
      if (wr_done) wr_done_total++;
      if (prev_rd_stall) begin  // stalled request must hold
        check_value("rd_valid", 32'(rd_valid), 32'd1);
        check_value("rd_addr", rd_addr, prev_rd_addr);
        check_value("rd_size", 32'(rd_size), 32'(prev_rd_size));
      end
      if (prev_wr_stall) begin
        check_value("wr_valid", 32'(wr_valid), 32'd1);
        check_value("wr_addr", wr_addr, prev_wr_addr);
        check_value("wr_size", 32'(wr_size), 32'(prev_wr_size));
      end
      prev_rd_stall = rd_valid && !rd_ready;
      prev_wr_stall = wr_valid && !wr_ready;
      prev_rd_addr  = rd_addr;
      prev_rd_size  = rd_size;
      prev_wr_addr  = wr_addr;
      prev_wr_size  = wr_size;
      if (rd_valid && rd_ready) begin
        if (exp_rd_addr.size() == 0) begin
          stop_on_error("read request accepted with no read left to expect");
        end else begin
          check_value("rd_addr", rd_addr, exp_rd_addr.pop_front());
          check_value("rd_size", 32'(rd_size), 32'(exp_rd_size.pop_front()));
          need = exp_rd_need.pop_front();
          if (wr_done_total < need) begin
            stop_on_error("read accepted before enough write descriptors completed");
          end
        end
      end
      if (wr_valid && wr_ready) begin
        if (exp_wr_addr.size() == 0) begin
          stop_on_error("write request accepted with no write left to expect");
        end else begin
          check_value("wr_addr", wr_addr, exp_wr_addr.pop_front());
          check_value("wr_size", 32'(wr_size), 32'(exp_wr_size.pop_front()));
          need = exp_wr_need.pop_front();
          if (wr_done_total != need) begin
            stop_on_error("write beat issued before the previous descriptor completed");
          end
          if (exp_wr_last.pop_front()) writes_finished++;
        end
      end
      if (done) begin
        done_total++;
        if (done_total != runs_started) begin
          stop_on_error("done pulsed more than once in a run");
        end else if (!wr_done || wr_done_total != wr_goal) begin
          stop_on_error("done raised without the last wr_done");
        end else if (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) begin
          stop_on_error("done raised with requests still outstanding");
        end
      end
    end
  end

  // watchdog on each run
  always @(posedge clk) begin
    cycle_count++;
    if (running && (cycle_count - run_start_cycle > cycle_limit)) begin
      stop_on_error("timeout: the run did not reach done within its cycle budget");
    end
  end

endmodule

// ==== list.f ====
+incdir+common
common/mem_ctrl_pkg.sv
rtl/loop_counter.sv
rtl/desc_table.sv
rd_path/rd_fsm.sv
rd_path/rd_addr_gen.sv
wr_path/wr_fsm.sv
rtl/mem_ctrl_top.sv
dv/mem_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module mem_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmem_ctrl_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
